/* build.f */
+incdir+.
mpmc_pkg.sv
mpmc_port_arbiter.sv
mpmc_refresh_gen.sv
mpmc_cmd_sequencer.sv
mpmc_resp_router.sv
mpmc_top.sv
tb_mpmc_mem.sv
tb_mpmc.sv

/* mpmc_cmd_sequencer.sv */
`timescale 1ns/1ps
`include "mpmc_settings.svh"

module mpmc_cmd_sequencer (
	input logic mem_ui_clk,
	input logic irst,
	input logic calib_complete,
	input logic ref_pending,
	input logic grant_valid,
	input mpmc_pkg::wb_req_t grant_req,
	input logic app_rdy,
	input logic app_wdf_rdy,
	input logic app_ref_ack,
	input logic app_rd_data_valid,
	output mpmc_pkg::app_cmd_t app_cmd,
	output mpmc_pkg::app_wdf_t app_wdf,
	output logic app_ref_req,
	output mpmc_pkg::mpmc_state_t state,
	output logic ref_done,
	output logic done
);
	import mpmc_pkg::*;

	logic cmd_en;
	logic [2:0] cmd_code;
	logic [`MPMC_APP_ADR_BITS-1:0] cmd_addr;
	logic wdf_wren;
	logic [`MPMC_SEL_BITS-1:0] wdf_mask;
	logic [`MPMC_WORD_BITS-1:0] wdf_data;
	logic cmd_taken;
	logic wdf_taken;
	logic cmd_ok;
	logic wdf_ok;
	logic start;
	logic [`MPMC_SEL_BITS-1:0] req_mask;
	logic [`MPMC_WORD_BITS-1:0] req_data;

	// ========================================================================
	// write lane shaping
	// ========================================================================

	// masked lanes carry all ones, the controller ignores them anyway
	always_comb begin
		req_mask = ~grant_req.sel;
		for (int i = 0; i < `MPMC_SEL_BITS; i++) begin
			req_data[i*8 +: 8] = req_mask[i] ? 8'hFF : grant_req.dat[i*8 +: 8];
		end
	end

	// refresh has priority over a waiting grant
	assign start = (state == IDLE) && calib_complete && !ref_pending && grant_valid;

	// accepted earlier, or being accepted on this edge
	assign cmd_ok = cmd_taken || (cmd_en && app_rdy);
	assign wdf_ok = wdf_taken || (wdf_wren && app_wdf_rdy);

	// ========================================================================
	// state machine
	// ========================================================================

	always_ff @(posedge mem_ui_clk) begin
		if (irst) begin
			state <= IDLE;
			cmd_en <= 1'b0;
			wdf_wren <= 1'b0;
			app_ref_req <= 1'b0;
			cmd_taken <= 1'b0;
			wdf_taken <= 1'b0;
		end else begin
			case (state)
			IDLE: begin
				cmd_taken <= 1'b0;
				wdf_taken <= 1'b0;
				if (calib_complete && ref_pending) begin
					app_ref_req <= 1'b1;
					state <= REFRESH;
				end else if (start) begin
					cmd_en <= 1'b1;
					wdf_wren <= grant_req.we;
					if (grant_req.we) begin
						state <= WRITE_CMD;
					end else begin
						state <= READ_CMD;
					end
				end
			end
			REFRESH: begin
				if (app_ref_ack) begin
					app_ref_req <= 1'b0;
					state <= IDLE;
				end
			end
			// command and data may be accepted on different cycles
			WRITE_CMD: begin
				if (cmd_en && app_rdy) begin
					cmd_en <= 1'b0;
					cmd_taken <= 1'b1;
				end
				if (wdf_wren && app_wdf_rdy) begin
					wdf_wren <= 1'b0;
					wdf_taken <= 1'b1;
				end
				if (cmd_ok && wdf_ok) begin
					state <= ACK;
				end
			end
			READ_CMD: begin
				if (app_rdy) begin
					cmd_en <= 1'b0;
					state <= READ_WAIT;
				end
			end
			READ_WAIT: begin
				if (app_rd_data_valid) begin
					state <= ACK;
				end
			end
			default: begin
				state <= IDLE;
			end
			endcase
		end
	end

	// command payload, loaded once per access
	always_ff @(posedge mem_ui_clk) begin
		if (start) begin
			cmd_code <= grant_req.we ? APP_CMD_WRITE : APP_CMD_READ;
			cmd_addr <= {grant_req.adr[`MPMC_APP_ADR_BITS-1:4], 4'b0000};
			wdf_mask <= req_mask;
			wdf_data <= req_data;
		end
	end

	always_comb begin
		app_cmd.en = cmd_en;
		app_cmd.cmd = cmd_code;
		app_cmd.addr = cmd_addr;
		app_wdf.wren = wdf_wren;
		// single beat, so every data beat is also the last one
		app_wdf.last = wdf_wren;
		app_wdf.mask = wdf_mask;
		app_wdf.data = wdf_data;
	end

	assign done = (state == ACK);
	assign ref_done = (state == REFRESH) && app_ref_ack;

	a_cmd_hold: assert property (@(posedge mem_ui_clk) disable iff (irst)
		(app_cmd.en && !app_rdy) |=> $stable(app_cmd));

	a_no_wren_in_read: assert property (@(posedge mem_ui_clk) disable iff (irst)
		(state == READ_CMD || state == READ_WAIT) |-> !app_wdf.wren);

endmodule

/* mpmc_pkg.sv */
`include "mpmc_settings.svh"

package mpmc_pkg;

	// app_cmd encodings of the memory controller
	localparam logic [2:0] APP_CMD_WRITE = 3'd0;
	localparam logic [2:0] APP_CMD_READ = 3'd1;

	// wishbone classic master side of one port
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`MPMC_SEL_BITS-1:0] sel;
		logic [`MPMC_ADR_BITS-1:0] adr;
		logic [`MPMC_WORD_BITS-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		logic [`MPMC_WORD_BITS-1:0] dat;
	} wb_resp_t;

	// app command channel
	typedef struct packed {
		logic en;
		logic [2:0] cmd;
		logic [`MPMC_APP_ADR_BITS-1:0] addr;
	} app_cmd_t;

	// app write data channel, last is the wdf end flag
	typedef struct packed {
		logic wren;
		logic last;
		logic [`MPMC_SEL_BITS-1:0] mask;
		logic [`MPMC_WORD_BITS-1:0] data;
	} app_wdf_t;

	typedef enum logic [2:0] {
		IDLE = 3'd0,
		REFRESH = 3'd1,
		WRITE_CMD = 3'd2,
		READ_CMD = 3'd3,
		READ_WAIT = 3'd4,
		ACK = 3'd5
	} mpmc_state_t;

endpackage

/* mpmc_port_arbiter.sv */
`timescale 1ns/1ps
`include "mpmc_settings.svh"

module mpmc_port_arbiter (
	input logic mem_ui_clk,
	input logic irst,
	input mpmc_pkg::wb_req_t [`MPMC_PORTS-1:0] wb_req,
	input mpmc_pkg::mpmc_state_t state,
	output logic grant_valid,
	output logic [`MPMC_PORT_BITS-1:0] grant_port,
	output mpmc_pkg::wb_req_t grant_req
);
	import mpmc_pkg::*;

	logic [`MPMC_PORTS-1:0] pend;
	logic [`MPMC_PORT_BITS-1:0] rr_ptr;
	logic pick_valid;
	logic [`MPMC_PORT_BITS-1:0] pick_port;
	logic take;

	always_comb begin
		for (int i = 0; i < `MPMC_PORTS; i++) begin
			pend[i] = wb_req[i].cyc & wb_req[i].stb;
		end
	end

	// first pending port searching upward from the pointer, wrapping around
	always_comb begin
		logic [`MPMC_PORT_BITS-1:0] idx;
		pick_valid = 1'b0;
		pick_port = rr_ptr;
		for (int k = 0; k < `MPMC_PORTS; k++) begin
			idx = rr_ptr + `MPMC_PORT_BITS'(k);
			if (!pick_valid && pend[idx]) begin
				pick_valid = 1'b1;
				pick_port = idx;
			end
		end
	end

	// only a free controller takes a new request
	assign take = (state == IDLE) && !grant_valid && pick_valid;

	always_ff @(posedge mem_ui_clk) begin
		if (irst) begin
			grant_valid <= 1'b0;
			rr_ptr <= '0;
		end else if (state == ACK) begin
			grant_valid <= 1'b0;
		end else if (take) begin
			grant_valid <= 1'b1;
			rr_ptr <= pick_port + 1'b1;
		end
	end

	// copy of the winning request, held until the access is done
	always_ff @(posedge mem_ui_clk) begin
		if (take) begin
			grant_port <= pick_port;
			grant_req <= wb_req[pick_port];
		end
	end

	a_grant_held: assert property (@(posedge mem_ui_clk) disable iff (irst)
		(grant_valid && state != IDLE) |=> $stable(grant_port));

endmodule

/* mpmc_refresh_gen.sv */
`timescale 1ns/1ps
`include "mpmc_settings.svh"

module mpmc_refresh_gen (
	input logic mem_ui_clk,
	input logic irst,
	input logic calib_complete,
	input logic ref_done,
	output logic ref_pending
);
	localparam int CNT_BITS = $clog2(`MPMC_REFRESH_INTERVAL);
	localparam logic [CNT_BITS-1:0] CNT_LAST = CNT_BITS'(`MPMC_REFRESH_INTERVAL - 1);

	logic [CNT_BITS-1:0] ref_cnt;
	logic wrap;

	assign wrap = calib_complete && (ref_cnt == CNT_LAST);

	// interval counter, held at zero until the memory is calibrated
	always_ff @(posedge mem_ui_clk) begin
		if (irst || !calib_complete) begin
			ref_cnt <= '0;
		end else if (wrap) begin
			ref_cnt <= '0;
		end else begin
			ref_cnt <= ref_cnt + 1'b1;
		end
	end

	// a new interval wins over a completion in the same cycle
	always_ff @(posedge mem_ui_clk) begin
		if (irst) begin
			ref_pending <= 1'b0;
		end else if (wrap) begin
			ref_pending <= 1'b1;
		end else if (ref_done) begin
			ref_pending <= 1'b0;
		end
	end

endmodule

/* mpmc_resp_router.sv */
`timescale 1ns/1ps
`include "mpmc_settings.svh"

module mpmc_resp_router (
	input logic mem_ui_clk,
	input logic irst,
	input logic done,
	input logic [`MPMC_PORT_BITS-1:0] grant_port,
	input logic app_rd_data_valid,
	input logic [`MPMC_WORD_BITS-1:0] app_rd_data,
	output mpmc_pkg::wb_resp_t [`MPMC_PORTS-1:0] wb_resp
);
	logic [`MPMC_WORD_BITS-1:0] rd_hold;
	logic [`MPMC_PORTS-1:0] ack;

	// last word returned by the controller
	always_ff @(posedge mem_ui_clk) begin
		if (app_rd_data_valid) begin
			rd_hold <= app_rd_data;
		end
	end

	// one ack pulse on the port that owns the finished access
	always_ff @(posedge mem_ui_clk) begin
		if (irst) begin
			ack <= '0;
		end else begin
			ack <= '0;
			if (done) begin
				ack[grant_port] <= 1'b1;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < `MPMC_PORTS; i++) begin
			wb_resp[i].ack = ack[i];
			wb_resp[i].dat = rd_hold;
		end
	end

	a_single_ack: assert property (@(posedge mem_ui_clk) disable iff (irst)
		$onehot0(ack));

endmodule

/* mpmc_settings.svh */
`ifndef MPMC_SETTINGS_SVH
`define MPMC_SETTINGS_SVH

// port side
`define MPMC_PORTS 4
`define MPMC_PORT_BITS 2

// data path, one memory word per access
`define MPMC_WORD_BITS 128
`define MPMC_SEL_BITS 16

// wishbone byte address
`define MPMC_ADR_BITS 32

// app interface word address
`define MPMC_APP_ADR_BITS 30

// clocks between refresh requests
`define MPMC_REFRESH_INTERVAL 512

`endif

/* mpmc_top.sv */
`timescale 1ns/1ps
`include "mpmc_settings.svh"

module mpmc_top (
	input logic mem_ui_clk,
	input logic irst,
	input logic calib_complete,
	input mpmc_pkg::wb_req_t [`MPMC_PORTS-1:0] wb_req,
	output mpmc_pkg::wb_resp_t [`MPMC_PORTS-1:0] wb_resp,
	output mpmc_pkg::app_cmd_t app_cmd,
	output mpmc_pkg::app_wdf_t app_wdf,
	input logic app_rdy,
	input logic app_wdf_rdy,
	input logic app_rd_data_valid,
	input logic [`MPMC_WORD_BITS-1:0] app_rd_data,
	output logic app_ref_req,
	input logic app_ref_ack
);
	import mpmc_pkg::*;

	mpmc_state_t state;
	logic grant_valid;
	logic [`MPMC_PORT_BITS-1:0] grant_port;
	wb_req_t grant_req;
	logic ref_pending;
	logic ref_done;
	logic done;

	// ========================================================================
	// port side
	// ========================================================================

	mpmc_port_arbiter u_arb (
		.mem_ui_clk(mem_ui_clk),
		.irst(irst),
		.wb_req(wb_req),
		.state(state),
		.grant_valid(grant_valid),
		.grant_port(grant_port),
		.grant_req(grant_req)
	);

	mpmc_resp_router u_router (
		.mem_ui_clk(mem_ui_clk),
		.irst(irst),
		.done(done),
		.grant_port(grant_port),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data),
		.wb_resp(wb_resp)
	);

	// ========================================================================
	// memory side
	// ========================================================================

	mpmc_refresh_gen u_ref (
		.mem_ui_clk(mem_ui_clk),
		.irst(irst),
		.calib_complete(calib_complete),
		.ref_done(ref_done),
		.ref_pending(ref_pending)
	);

	mpmc_cmd_sequencer u_seq (
		.mem_ui_clk(mem_ui_clk),
		.irst(irst),
		.calib_complete(calib_complete),
		.ref_pending(ref_pending),
		.grant_valid(grant_valid),
		.grant_req(grant_req),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.app_ref_ack(app_ref_ack),
		.app_rd_data_valid(app_rd_data_valid),
		.app_cmd(app_cmd),
		.app_wdf(app_wdf),
		.app_ref_req(app_ref_req),
		.state(state),
		.ref_done(ref_done),
		.done(done)
	);

endmodule

/* run_sim.sh */
#!/bin/bash
# builds the testbench with Verilator and runs it; a $fatal gives a failing exit status
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f build.f \
	--top-module tb_mpmc \
	-o sim_mpmc \
	&& ./obj_dir/sim_mpmc \
	&& echo "simulation finished" \
	|| { echo "simulation did not pass"; exit 1; }

/* tb_mpmc.sv */
`timescale 1ns/1ps
`include "mpmc_settings.svh"

module tb_mpmc;
	import mpmc_pkg::*;

	localparam int RST_CYCLES = 8;
	localparam int CAL_CYCLES = 20;
	localparam int PER_PORT = 400;
	localparam int LIMIT = `MPMC_PORTS * PER_PORT * 40 + RST_CYCLES + CAL_CYCLES;
	localparam int REF_GAP_MAX = `MPMC_REFRESH_INTERVAL + 64;

	logic mem_ui_clk = 1'b0;
	logic irst;
	logic calib_complete;
	wb_req_t [`MPMC_PORTS-1:0] wb_req;
	wb_resp_t [`MPMC_PORTS-1:0] wb_resp;
	app_cmd_t app_cmd;
	app_wdf_t app_wdf;
	logic app_rdy;
	logic app_wdf_rdy;
	logic app_rd_data_valid;
	logic [`MPMC_WORD_BITS-1:0] app_rd_data;
	logic app_ref_req;
	logic app_ref_ack;
	logic rdy_drop;
	logic wdf_drop;
	logic [3:0] rd_lat;
	logic [2:0] ref_lat;

	logic [31:0] lfsr;
	int cycles;
	logic [7:0] ref_mem [0:255];
	logic [`MPMC_PORTS-1:0] busy;
	logic [`MPMC_PORTS-1:0] must_pend;
	int issued [`MPMC_PORTS];
	int cooldown [`MPMC_PORTS];
	logic [`MPMC_PORT_BITS-1:0] rr_ptr;
	app_cmd_t seen_cmd;
	app_cmd_t prev_cmd;
	app_wdf_t seen_wdf;
	logic prev_rdy;
	logic prev_wren;
	logic prev_ref;
	int ref_gap;

	mpmc_top uut (
		.mem_ui_clk(mem_ui_clk),
		.irst(irst),
		.calib_complete(calib_complete),
		.wb_req(wb_req),
		.wb_resp(wb_resp),
		.app_cmd(app_cmd),
		.app_wdf(app_wdf),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data),
		.app_ref_req(app_ref_req),
		.app_ref_ack(app_ref_ack)
	);

	tb_mpmc_mem u_mem (
		.mem_ui_clk(mem_ui_clk),
		.irst(irst),
		.app_cmd(app_cmd),
		.app_wdf(app_wdf),
		.app_ref_req(app_ref_req),
		.rdy_drop(rdy_drop),
		.wdf_drop(wdf_drop),
		.rd_lat(rd_lat),
		.ref_lat(ref_lat),
		.app_rdy(app_rdy),
		.app_wdf_rdy(app_wdf_rdy),
		.app_rd_data_valid(app_rd_data_valid),
		.app_rd_data(app_rd_data),
		.app_ref_ack(app_ref_ack)
	);

	always #50 mem_ui_clk = ~mem_ui_clk;

	// ========================================================================
	// random bits and error handling
	// ========================================================================

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [`MPMC_WORD_BITS-1:0] exp,
			input logic [`MPMC_WORD_BITS-1:0] got);
		if (exp !== got) begin
			fail_now($sformatf("Mismatch %s exp %h got %h", name, exp, got));
		end
	endtask

	task automatic check_port(input string name, input logic [`MPMC_PORT_BITS-1:0] exp,
			input logic [`MPMC_PORT_BITS-1:0] got);
		if (exp !== got) begin
			fail_now($sformatf("Mismatch %s exp %h got %h", name, exp, got));
		end
	endtask

	task automatic check_app_cmd(input string name, input app_cmd_t exp, input app_cmd_t got);
		if (exp !== got) begin
			fail_now($sformatf("Mismatch %s exp %h got %h", name, exp, got));
		end
	endtask

	task automatic check_app_wdf(input string name, input app_wdf_t exp, input app_wdf_t got);
		if (exp !== got) begin
			fail_now($sformatf("Mismatch %s exp %h got %h", name, exp, got));
		end
	endtask

	// ========================================================================
	// monitors
	// ========================================================================

	task automatic watch_app();
		if (!calib_complete && (app_cmd.en || app_wdf.wren || app_ref_req)) begin
			fail_now("memory interface active before calibration completed");
		end
		if (app_cmd.en && app_ref_req) begin
			fail_now("app_en asserted while a refresh request was open");
		end
		if (app_cmd.en && !prev_cmd.en) begin
			seen_cmd = app_cmd;
		end
		if (prev_cmd.en && !prev_rdy) begin
			check_app_cmd("app_cmd held", prev_cmd, app_cmd);
		end
		if (app_wdf.wren && !prev_wren) begin
			seen_wdf = app_wdf;
			if (seen_cmd.cmd != APP_CMD_WRITE) begin
				fail_now("write data strobe raised during a read");
			end
		end
		// refresh must come round once per interval plus one access
		if (calib_complete) begin
			ref_gap++;
			if (app_ref_req && !prev_ref) begin
				ref_gap = 0;
			end
			if (ref_gap > REF_GAP_MAX) begin
				fail_now("no refresh request within the refresh interval");
			end
		end
	endtask

	task automatic serve_ack(input int p);
		logic [`MPMC_PORT_BITS-1:0] exp_port;
		logic [`MPMC_PORT_BITS-1:0] idx;
		logic [`MPMC_WORD_BITS-1:0] exp_word;
		app_cmd_t exp_cmd;
		app_wdf_t exp_wdf;
		int w;
		exp_port = `MPMC_PORT_BITS'(p);
		// first port from the pointer that was surely waiting at grant time
		for (int k = `MPMC_PORTS - 1; k >= 0; k--) begin
			idx = rr_ptr + `MPMC_PORT_BITS'(k);
			if (must_pend[idx] || idx == `MPMC_PORT_BITS'(p)) begin
				exp_port = idx;
			end
		end
		check_port("ack_port", exp_port, `MPMC_PORT_BITS'(p));
		w = int'(wb_req[p].adr[7:4]);
		exp_cmd.en = 1'b1;
		exp_cmd.cmd = wb_req[p].we ? APP_CMD_WRITE : APP_CMD_READ;
		// word index times sixteen bytes
		exp_cmd.addr = `MPMC_APP_ADR_BITS'(w * 16);
		check_app_cmd("app_cmd", exp_cmd, seen_cmd);
		if (wb_req[p].we) begin
			exp_wdf.wren = 1'b1;
			exp_wdf.last = 1'b1;
			exp_wdf.mask = ~wb_req[p].sel;
			// unselected lanes go out as all ones
			for (int i = 0; i < `MPMC_SEL_BITS; i++) begin
				if (wb_req[p].sel[i]) begin
					exp_wdf.data[i*8 +: 8] = wb_req[p].dat[i*8 +: 8];
				end else begin
					exp_wdf.data[i*8 +: 8] = 8'hFF;
				end
			end
			check_app_wdf("app_wdf", exp_wdf, seen_wdf);
			for (int i = 0; i < `MPMC_SEL_BITS; i++) begin
				if (wb_req[p].sel[i]) begin
					ref_mem[w*16 + i] = wb_req[p].dat[i*8 +: 8];
				end
			end
		end else begin
			for (int i = 0; i < `MPMC_SEL_BITS; i++) begin
				exp_word[i*8 +: 8] = ref_mem[w*16 + i];
			end
			check_word("wb_dat", exp_word, wb_resp[p].dat);
		end
		rr_ptr = `MPMC_PORT_BITS'(p) + 1'b1;
		busy[p] = 1'b0;
		wb_req[p].cyc = 1'b0;
		wb_req[p].stb = 1'b0;
		cooldown[p] = 1 + int'(rand_bits(2));
	endtask

	// ========================================================================
	// stimulus, all on the falling edge
	// ========================================================================

	task automatic new_request(input int p);
		wb_req[p].we = rand_bits(1) != 0;
		wb_req[p].sel = `MPMC_SEL_BITS'(rand_bits(16));
		wb_req[p].adr = {24'd0, 8'(rand_bits(8))};
		for (int i = 0; i < 4; i++) begin
			wb_req[p].dat[i*32 +: 32] = rand_bits(32);
		end
		wb_req[p].cyc = 1'b1;
		wb_req[p].stb = 1'b1;
		busy[p] = 1'b1;
		issued[p]++;
	endtask

	always @(negedge mem_ui_clk) begin
		int n_ack;
		int finished;
		n_ack = 0;
		finished = 0;
		if (!irst) begin
			watch_app();
			for (int p = 0; p < `MPMC_PORTS; p++) begin
				if (wb_resp[p].ack) begin
					n_ack++;
					if (!calib_complete) begin
						fail_now("ack seen before calibration completed");
					end
					if (!busy[p]) begin
						fail_now($sformatf("ack on port %0d without a request", p));
					end
					serve_ack(p);
				end
			end
			if (n_ack > 1) begin
				fail_now("more than one ack in the same cycle");
			end
		end
		if (cycles >= RST_CYCLES) begin
			irst = 1'b0;
		end
		if (cycles >= RST_CYCLES + CAL_CYCLES) begin
			calib_complete = 1'b1;
		end
		rdy_drop = rand_bits(2) == 0;
		wdf_drop = rand_bits(2) == 0;
		rd_lat = 4'd2 + 4'(rand_bits(3));
		ref_lat = 3'd1 + 3'(rand_bits(3) % 6);
		if (!irst) begin
			for (int p = 0; p < `MPMC_PORTS; p++) begin
				if (!busy[p] && cooldown[p] > 0) begin
					cooldown[p]--;
				end else if (!busy[p] && issued[p] < PER_PORT && rand_bits(1) != 0) begin
					new_request(p);
				end
				if (!busy[p] && issued[p] >= PER_PORT) begin
					finished++;
				end
			end
		end
		if (n_ack > 0) begin
			must_pend = busy;
		end
		prev_cmd = app_cmd;
		// app_rdy as the controller sees it on the coming rising edge
		prev_rdy = !rdy_drop;
		prev_wren = app_wdf.wren;
		prev_ref = app_ref_req;
		if (finished == `MPMC_PORTS) begin
			$display("Result: PASSED");
			$finish;
		end
	end

	always @(posedge mem_ui_clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("run timed out before all transactions completed");
			$display("Result: FAILED");
			$fatal(1);
		end
	end

	initial begin
		lfsr = 32'he676_63aa;
		irst = 1'b1;
		calib_complete = 1'b0;
		wb_req = '0;
		rdy_drop = 1'b0;
		wdf_drop = 1'b0;
		rd_lat = 4'd2;
		ref_lat = 3'd1;
		cycles = 0;
		busy = '0;
		must_pend = '0;
		rr_ptr = '0;
		seen_cmd = '0;
		prev_cmd = '0;
		seen_wdf = '0;
		prev_rdy = 1'b0;
		prev_wren = 1'b0;
		prev_ref = 1'b0;
		ref_gap = 0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = 8'h00;
		end
		for (int p = 0; p < `MPMC_PORTS; p++) begin
			issued[p] = 0;
			cooldown[p] = 0;
		end
	end

endmodule

/* tb_mpmc_mem.sv */
`timescale 1ns/1ps
`include "mpmc_settings.svh"

module tb_mpmc_mem (
	input logic mem_ui_clk,
	input logic irst,
	input mpmc_pkg::app_cmd_t app_cmd,
	input mpmc_pkg::app_wdf_t app_wdf,
	input logic app_ref_req,
	input logic rdy_drop,
	input logic wdf_drop,
	input logic [3:0] rd_lat,
	input logic [2:0] ref_lat,
	output logic app_rdy,
	output logic app_wdf_rdy,
	output logic app_rd_data_valid,
	output logic [`MPMC_WORD_BITS-1:0] app_rd_data,
	output logic app_ref_ack
);
	import mpmc_pkg::*;

	// sparse word storage, unwritten words read as zero
	logic [`MPMC_WORD_BITS-1:0] mem [logic [`MPMC_APP_ADR_BITS-1:0]];

	logic have_adr;
	logic have_dat;
	logic [`MPMC_APP_ADR_BITS-1:0] wr_addr;
	logic [`MPMC_SEL_BITS-1:0] wr_mask;
	logic [`MPMC_WORD_BITS-1:0] wr_data;
	logic [`MPMC_APP_ADR_BITS-1:0] rd_addr;
	logic [3:0] rd_cnt;
	logic [2:0] ref_cnt;

	assign app_rdy = !rdy_drop;
	assign app_wdf_rdy = !wdf_drop;

	always @(posedge mem_ui_clk) begin
		logic [`MPMC_WORD_BITS-1:0] word;
		if (irst) begin
			have_adr = 1'b0;
			have_dat = 1'b0;
			rd_cnt = '0;
			ref_cnt = '0;
			app_rd_data_valid <= 1'b0;
			app_rd_data <= '0;
			app_ref_ack <= 1'b0;
		end else begin
			// ====================================================================
			// command and write data acceptance
			// ====================================================================
			if (app_cmd.en && app_rdy && app_cmd.cmd == APP_CMD_WRITE) begin
				have_adr = 1'b1;
				wr_addr = app_cmd.addr;
			end
			if (app_wdf.wren && app_wdf_rdy) begin
				have_dat = 1'b1;
				wr_mask = app_wdf.mask;
				wr_data = app_wdf.data;
			end
			// masked lanes keep what was stored before
			if (have_adr && have_dat) begin
				word = mem.exists(wr_addr) ? mem[wr_addr] : '0;
				for (int i = 0; i < `MPMC_SEL_BITS; i++) begin
					if (!wr_mask[i]) begin
						word[i*8 +: 8] = wr_data[i*8 +: 8];
					end
				end
				mem[wr_addr] = word;
				have_adr = 1'b0;
				have_dat = 1'b0;
			end

			// read return after the chosen latency
			app_rd_data_valid <= 1'b0;
			if (rd_cnt != 0) begin
				rd_cnt = rd_cnt - 4'd1;
				if (rd_cnt == 0) begin
					app_rd_data_valid <= 1'b1;
					app_rd_data <= mem.exists(rd_addr) ? mem[rd_addr] : '0;
				end
			end
			if (app_cmd.en && app_rdy && app_cmd.cmd == APP_CMD_READ) begin
				rd_addr = app_cmd.addr;
				rd_cnt = rd_lat;
			end

			// refresh handshake
			app_ref_ack <= 1'b0;
			if (ref_cnt != 0) begin
				ref_cnt = ref_cnt - 3'd1;
				if (ref_cnt == 0) begin
					app_ref_ack <= 1'b1;
				end
			end else if (app_ref_req && !app_ref_ack) begin
				ref_cnt = ref_lat;
			end
		end
	end

endmodule
